//--- cgra_top.f
+incdir+include
source/cgra_pkg.sv
source/frame_timer.sv
source/run_sequencer.sv
source/pe_cell.sv
source/lsu_unit.sv
source/pe_row.sv
source/pe_array.sv
source/cgra_top.sv
tests/cgra_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --timing -Wno-fatal
TOP       = cgra_tb
FILELIST  = cgra_top.f
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tests/cgra_tb.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module cgra_tb;
    import cgra_pkg::*;

    // Seven fixed starts with 23 iterations, twenty random starts of up to 15,
    // and about 40 cycles of setup per start.
    localparam int CYCLE_LIMIT = 23 * 8 + 7 * 20 + 20 * (15 * 8 + 20) + 27 * 40 + 20;

    logic                               clk;
    logic                               reset;
    logic                               start;
    logic [`ITER_W-1:0]                 iterations;
    logic                               busy;
    logic                               done;
    cfg_write_t                         cfg;
    mem_rd_t [`CGRA_ROWS-1:0]           mem_rd;
    mem_wr_t [`CGRA_ROWS-1:0]           mem_wr;
    logic [`CGRA_ROWS-1:0][`DATA_W-1:0] mem_rd_data;

    logic [`DATA_W-1:0] mem [`CGRA_ROWS][2**`ADDR_W];
    pe_config_t         pe_sh [`CGRA_ROWS][`CGRA_COLS];
    lsu_config_t        lsu_sh [`CGRA_ROWS];
    logic [41:0]        exp_q [$];   // Row, address, data.
    int                 rd_count [`CGRA_ROWS];
    int                 rd_first [`CGRA_ROWS];
    logic               fill_go;
    logic [31:0]        fill_key;
    logic [31:0]        seed = 32'ha96a4a0a;
    int                 errors = 0;
    int                 mon_errors = 0;
    int                 tests = 0;
    int                 fails = 0;
    int                 base = 0;
    int                 cycles = 0;
    string              test_name = "none";

    cgra_top dut (
        .clk         (clk),
        .reset       (reset),
        .cfg         (cfg),
        .start       (start),
        .iterations  (iterations),
        .busy        (busy),
        .done        (done),
        .mem_rd      (mem_rd),
        .mem_rd_data (mem_rd_data),
        .mem_wr      (mem_wr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] fill_word(input int r, input int a, input logic [31:0] key);
        logic [31:0] x;
        x = key ^ ((32'(r) << 8) | 32'(a));
        x = x * 32'h9e3779b1;
        x = x ^ (x >> 15);
        return x * 32'h85ebca6b;
    endfunction

    // Row memories, read combinationally.
    always @(posedge clk) begin
        if (fill_go) begin
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                for (int a = 0; a < 2**`ADDR_W; a++) mem[r][a] <= fill_word(r, a, fill_key);
            end
        end else begin
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                if (mem_wr[r].req) mem[r][mem_wr[r].addr] <= mem_wr[r].data;
            end
        end
    end

    always_comb begin
        for (int r = 0; r < `CGRA_ROWS; r++) mem_rd_data[r] = mem[r][mem_rd[r].addr];
    end

    function automatic logic [31:0] alu(input pe_op_t op, input logic [31:0] a, input logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            MUL:     return a * b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SHL:     return a << b[4:0];
            default: return a;
        endcase
    endfunction

    function automatic logic [31:0] operand(input src_sel_t sel, input logic [31:0] n,
                                            input logic [31:0] s, input logic [31:0] w,
                                            input logic [31:0] self, input logic [15:0] imm);
        case (sel)
            SRC_NORTH: return n;
            SRC_SOUTH: return s;
            SRC_WEST:  return w;
            SRC_SELF:  return self;
            SRC_IMM:   return 32'(imm);
            default:   return 32'd0;   // Unused codes read zero.
        endcase
    endfunction

    // Software grid, stepped frame by frame; queues the expected writes.
    function automatic void golden_run(input int iters);
        logic [31:0] g [`CGRA_ROWS][`CGRA_COLS];
        logic [31:0] nxt [`CGRA_ROWS][`CGRA_COLS];
        logic [31:0] ld [`CGRA_ROWS];
        logic [31:0] gm [`CGRA_ROWS][2**`ADDR_W];
        logic [31:0] n;
        logic [31:0] s;
        logic [31:0] w;
        logic [7:0]  addr;
        pe_config_t  pc;
        gm = mem;
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            for (int c = 0; c < `CGRA_COLS; c++) g[r][c] = '0;
        end
        for (int k = 0; k < iters; k++) begin
            for (int r = 0; r < `CGRA_ROWS; r++) ld[r] = gm[r][lsu_sh[r].rd_base + 8'(k)];
            repeat (6) begin
                for (int r = 0; r < `CGRA_ROWS; r++) begin
                    for (int c = 0; c < `CGRA_COLS; c++) begin
                        pc = pe_sh[r][c];
                        n = (r > 0) ? g[r-1][c] : '0;
                        s = (r < `CGRA_ROWS - 1) ? g[r+1][c] : '0;
                        w = (c > 0) ? g[r][c-1] : ld[r];
                        nxt[r][c] = alu(pc.op, operand(pc.src_a, n, s, w, g[r][c], pc.imm),
                                        operand(pc.src_b, n, s, w, g[r][c], pc.imm));
                    end
                end
                g = nxt;
            end
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                if (lsu_sh[r].wr_en) begin
                    addr = lsu_sh[r].wr_base + 8'(k);
                    exp_q.push_back({2'(r), addr, g[r][`CGRA_COLS-1]});
                    gm[r][addr] = g[r][`CGRA_COLS-1];   // Later loads may see it.
                end
            end
        end
    endfunction

    // Compares every read address and every write against the golden queue.
    always @(negedge clk) begin : compare
        logic [41:0]        want;
        logic [41:0]        got;
        logic [`ADDR_W-1:0] rd_want;
        if (!reset) begin
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                if (mem_rd[r].req && !busy) begin
                    $display("%s: row %0d issued a read while idle", test_name, r);
                    mon_errors++;
                end else if (mem_rd[r].req) begin
                    // Frame k of a run reads rd_base + k.
                    rd_want = lsu_sh[r].rd_base + `ADDR_W'(rd_count[r] - rd_first[r]);
                    if (mem_rd[r].addr != rd_want) begin
                        $display("CHECK FAILED %s: row %0d read address expected %h actual %h",
                                 test_name, r, rd_want, mem_rd[r].addr);
                        mon_errors++;
                    end
                    rd_count[r]++;
                end
                if (mem_wr[r].req) begin
                    got = {2'(r), mem_wr[r].addr, mem_wr[r].data};
                    if (exp_q.size() == 0) begin
                        $display("%s: unexpected write on row %0d", test_name, r);
                        mon_errors++;
                    end else begin
                        want = exp_q.pop_front();
                        if (got != want) begin
                            $display("CHECK FAILED %s: expected %h actual %h", test_name, want, got);
                            mon_errors++;
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("test failed");
            $finish;
        end
    end

    task automatic write_cfg(input int row, input int slot, input logic [24:0] word);
        @(posedge clk);
        #1;
        cfg.valid = 1'b1;
        cfg.row   = 2'(row);
        cfg.slot  = 2'(slot);
        cfg.word  = word;
        @(posedge clk);
        #1;
        cfg.valid = 1'b0;
        if (slot == 3) lsu_sh[row] = lsu_config_t'(word[16:0]);
        else pe_sh[row][slot] = pe_config_t'(word);
    endtask

    task automatic set_pe(input int r, input int c, input pe_op_t op, input src_sel_t sa,
                          input src_sel_t sb, input logic [15:0] imm);
        write_cfg(r, c, {op, sa, sb, imm});
    endtask

    task automatic set_lsu(input int r, input int rd, input int wr, input bit en);
        write_cfg(r, 3, 25'({8'(rd), 8'(wr), en}));
    endtask

    task automatic fill_memory(input logic [31:0] key);
        @(posedge clk);
        #1;
        fill_key = key;
        fill_go  = 1'b1;
        @(posedge clk);
        #1;
        fill_go = 1'b0;
    endtask

    // Starts a run and counts edges up to the one that samples done.
    task automatic run_test(input int iters, input bit poke);
        int n;
        golden_run(iters);
        for (int r = 0; r < `CGRA_ROWS; r++) rd_first[r] = rd_count[r];
        @(posedge clk);
        #1;
        start      = 1'b1;
        iterations = `ITER_W'(iters);
        @(posedge clk);
        #1;
        start = 1'b0;
        n = 1;
        if (iters > 0 && !busy) begin
            $display("%s: busy did not rise after start", test_name);
            errors++;
        end
        while (!done) begin
            @(posedge clk);
            #1;
            n++;
            if (poke && n == 4) begin
                cfg   = {1'b1, 2'd0, 2'd2, 25'h1abcdef};   // Must be ignored.
                start = 1'b1;
            end
            if (poke && n == 5) begin
                cfg.valid = 1'b0;
                start     = 1'b0;
            end
        end
        if (n != iters * 8 + 1) begin
            $display("CHECK FAILED %s: done latency expected %0d actual %0d",
                     test_name, iters * 8 + 1, n);
            errors++;
        end
        if (busy) begin
            $display("%s: busy still high with done", test_name);
            errors++;
        end
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            if (rd_count[r] - rd_first[r] != iters) begin
                $display("CHECK FAILED %s: row %0d reads expected %0d actual %0d",
                         test_name, r, iters, rd_count[r] - rd_first[r]);
                errors++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected writes never happened", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        @(posedge clk);
        #1;
        if (done) begin
            $display("%s: done stayed high for more than one cycle", test_name);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        base = errors + mon_errors;
    endtask

    task automatic end_test();
        int bad;
        bad = errors + mon_errors - base;
        tests++;
        if (bad != 0) fails++;
        $display("%s: %s (%0d errors)", test_name, (bad == 0) ? "ok" : "FAIL", bad);
    endtask

    initial begin
        logic [31:0] w;
        int          iters;
        reset = 1'b1;
        start = 1'b0;
        iterations = '0;
        cfg = '0;
        fill_go = 1'b1;   // Memories hold a known pattern from the first reset edge.
        fill_key = '0;
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            lsu_sh[r] = '0;
            for (int c = 0; c < `CGRA_COLS; c++) pe_sh[r][c] = '0;
        end
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        fill_go = 1'b0;

        begin_test("reset_idle");
        repeat (10) begin
            @(posedge clk);
            #1;
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                if (busy || done || mem_rd[r].req || mem_wr[r].req) begin
                    $display("%s: outputs not quiet after reset", test_name);
                    errors++;
                end
            end
        end
        run_test(0, 0);
        end_test();

        begin_test("pass_through");
        fill_memory(32'h0000_1111);
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            for (int c = 0; c < `CGRA_COLS; c++) set_pe(r, c, PASS_A, SRC_WEST, SRC_ZERO, 16'd0);
            set_lsu(r, r * 16 + 3, 128 + r * 8, r != 2);   // Row 2 stays silent.
        end
        run_test(5, 0);
        end_test();

        begin_test("arithmetic");
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            if (r < 2) set_pe(r, 0, ADD, SRC_WEST, SRC_IMM, 16'(4660 + r));
            else set_pe(r, 0, SUB, SRC_WEST, SRC_IMM, 16'(257 * r));
            set_pe(r, 1, MUL, SRC_WEST, SRC_IMM, 16'(r + 3));
            if (r % 2 == 1) set_pe(r, 2, SHL, SRC_WEST, SRC_IMM, 16'(r + 1));
            else set_pe(r, 2, XOR, SRC_WEST, SRC_SELF, 16'd0);
            set_lsu(r, r * 16 + 3, 128 + r * 8, 1'b1);
        end
        run_test(4, 0);
        end_test();

        begin_test("vertical");
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            set_pe(r, 0, PASS_A, SRC_WEST, SRC_ZERO, 16'd0);
            set_pe(r, 1, ADD, SRC_NORTH, SRC_SOUTH, 16'd0);
            set_pe(r, 2, OR, SRC_NORTH, SRC_WEST, 16'd0);
        end
        run_test(3, 0);
        end_test();

        begin_test("accumulate");
        for (int r = 0; r < `CGRA_ROWS; r++) begin
            set_pe(r, 1, PASS_A, SRC_WEST, SRC_ZERO, 16'd0);
            set_pe(r, 2, ADD, SRC_SELF, SRC_WEST, 16'd0);
        end
        run_test(4, 0);
        run_test(4, 0);   // Starts again from zero.
        end_test();

        begin_test("gating");
        run_test(3, 1);
        end_test();

        begin_test("random");
        repeat (20) begin
            fill_memory(lcg_next());
            for (int r = 0; r < `CGRA_ROWS; r++) begin
                for (int c = 0; c < `CGRA_COLS; c++) begin
                    w = lcg_next();
                    write_cfg(r, c, w[24:0]);
                end
                w = lcg_next();
                write_cfg(r, 3, {8'd0, w[16:0]});
            end
            iters = int'(lcg_next() % 16);
            run_test(iters, 0);
        end
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests, fails, errors + mon_errors);
        if (fails == 0 && errors + mon_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- source/cgra_top.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module cgra_top (
    input  logic                                clk,
    input  logic                                reset,
    input  cgra_pkg::cfg_write_t                cfg,
    input  logic                                start,
    input  logic [`ITER_W-1:0]                  iterations,
    output logic                                busy,
    output logic                                done,
    output cgra_pkg::mem_rd_t [`CGRA_ROWS-1:0]  mem_rd,
    input  logic [`CGRA_ROWS-1:0][`DATA_W-1:0]  mem_rd_data,
    output cgra_pkg::mem_wr_t [`CGRA_ROWS-1:0]  mem_wr
);
    logic               cfg_en;
    logic               clear;
    logic               frame_run;
    logic               load_phase;
    logic               compute_phase;
    logic               store_phase;
    logic               frame_end;
    logic [`ITER_W-1:0] iter_index;

    run_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .iterations (iterations),
        .cfg_valid  (cfg.valid),
        .frame_end  (frame_end),
        .cfg_en     (cfg_en),
        .clear      (clear),
        .frame_run  (frame_run),
        .busy       (busy),
        .done       (done)
    );

    frame_timer u_timer (
        .clk           (clk),
        .reset         (reset),
        .frame_run     (frame_run),
        .iterations    (iterations),
        .load_phase    (load_phase),
        .compute_phase (compute_phase),
        .store_phase   (store_phase),
        .frame_end     (frame_end),
        .iter_index    (iter_index)
    );

    pe_array u_array (
        .clk           (clk),
        .reset         (reset),
        .clear         (clear),
        .cfg_en        (cfg_en),
        .cfg           (cfg),
        .load_phase    (load_phase),
        .compute_phase (compute_phase),
        .store_phase   (store_phase),
        .iter_index    (iter_index),
        .rd_data       (mem_rd_data),
        .mem_rd        (mem_rd),
        .mem_wr        (mem_wr)
    );

endmodule

//--- source/pe_array.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module pe_array (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                clear,
    input  logic                                cfg_en,
    input  cgra_pkg::cfg_write_t                cfg,
    input  logic                                load_phase,
    input  logic                                compute_phase,
    input  logic                                store_phase,
    input  logic [`ITER_W-1:0]                  iter_index,
    input  logic [`CGRA_ROWS-1:0][`DATA_W-1:0]  rd_data,
    output cgra_pkg::mem_rd_t [`CGRA_ROWS-1:0]  mem_rd,
    output cgra_pkg::mem_wr_t [`CGRA_ROWS-1:0]  mem_wr
);
    logic [`CGRA_ROWS-1:0]                                row_sel;
    logic [`CGRA_ROWS-1:0][`CGRA_COLS-1:0][`DATA_W-1:0]   grid_out;
    logic [`CGRA_ROWS-1:0][`CGRA_COLS-1:0][`DATA_W-1:0]   north_link;
    logic [`CGRA_ROWS-1:0][`CGRA_COLS-1:0][`DATA_W-1:0]   south_link;

    assign row_sel = `CGRA_ROWS'(1) << cfg.row;   // One hot.

    for (genvar r = 0; r < `CGRA_ROWS; r++) begin : g_row
        // Top and bottom rows see zero past the edge.
        if (r == 0) begin : g_top_edge
            assign north_link[r] = '0;
        end else begin : g_north
            assign north_link[r] = grid_out[r-1];
        end

        if (r == `CGRA_ROWS - 1) begin : g_bottom_edge
            assign south_link[r] = '0;
        end else begin : g_south
            assign south_link[r] = grid_out[r+1];
        end

        pe_row u_row (
            .clk           (clk),
            .reset         (reset),
            .clear         (clear),
            .cfg_en        (cfg_en),
            .cfg           (cfg),
            .row_sel       (row_sel[r]),
            .load_phase    (load_phase),
            .compute_phase (compute_phase),
            .store_phase   (store_phase),
            .iter_index    (iter_index),
            .north_in      (north_link[r]),
            .south_in      (south_link[r]),
            .rd_data       (rd_data[r]),
            .row_out       (grid_out[r]),
            .mem_rd        (mem_rd[r]),
            .mem_wr        (mem_wr[r])
        );
    end

endmodule

//--- source/pe_row.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module pe_row (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 clear,
    input  logic                                 cfg_en,
    input  cgra_pkg::cfg_write_t                 cfg,
    input  logic                                 row_sel,
    input  logic                                 load_phase,
    input  logic                                 compute_phase,
    input  logic                                 store_phase,
    input  logic [`ITER_W-1:0]                   iter_index,
    input  logic [`CGRA_COLS-1:0][`DATA_W-1:0]   north_in,
    input  logic [`CGRA_COLS-1:0][`DATA_W-1:0]   south_in,
    input  logic [`DATA_W-1:0]                   rd_data,
    output logic [`CGRA_COLS-1:0][`DATA_W-1:0]   row_out,
    output cgra_pkg::mem_rd_t                    mem_rd,
    output cgra_pkg::mem_wr_t                    mem_wr
);
    import cgra_pkg::*;

    logic                                row_wr;
    logic                                lsu_load;
    logic [`CGRA_COLS-1:0]               pe_load;
    logic [`DATA_W-1:0]                  load_data;
    logic [`CGRA_COLS-1:0][`DATA_W-1:0]  west_link;

    assign row_wr   = cfg_en && row_sel;
    assign lsu_load = row_wr && (cfg.slot == LSU_SLOT);

    lsu_unit u_lsu (
        .clk         (clk),
        .reset       (reset),
        .clear       (clear),
        .cfg_load    (lsu_load),
        .cfg_word    (lsu_config_t'(cfg.word[$bits(lsu_config_t)-1:0])),
        .load_phase  (load_phase),
        .store_phase (store_phase),
        .iter_index  (iter_index),
        .rd_data     (rd_data),
        .store_data  (row_out[`CGRA_COLS-1]),   // East end of the chain.
        .mem_rd      (mem_rd),
        .mem_wr      (mem_wr),
        .load_data   (load_data)
    );

    for (genvar c = 0; c < `CGRA_COLS; c++) begin : g_col
        assign pe_load[c] = row_wr && (cfg.slot == 2'(c));

        // West input is the load register for the first PE.
        if (c == 0) begin : g_first
            assign west_link[c] = load_data;
        end else begin : g_chain
            assign west_link[c] = row_out[c-1];
        end

        pe_cell u_pe (
            .clk      (clk),
            .reset    (reset),
            .clear    (clear),
            .cfg_load (pe_load[c]),
            .cfg_word (pe_config_t'(cfg.word)),
            .step     (compute_phase),
            .north_in (north_in[c]),
            .south_in (south_in[c]),
            .west_in  (west_link[c]),
            .data_out (row_out[c])
        );
    end

endmodule

//--- source/lsu_unit.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module lsu_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  clear,
    input  logic                  cfg_load,
    input  cgra_pkg::lsu_config_t cfg_word,
    input  logic                  load_phase,
    input  logic                  store_phase,
    input  logic [`ITER_W-1:0]    iter_index,
    input  logic [`DATA_W-1:0]    rd_data,
    input  logic [`DATA_W-1:0]    store_data,
    output cgra_pkg::mem_rd_t     mem_rd,
    output cgra_pkg::mem_wr_t     mem_wr,
    output logic [`DATA_W-1:0]    load_data
);
    import cgra_pkg::*;

    lsu_config_t        cfg_q;
    logic [`ADDR_W-1:0] offset;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (cfg_load) begin
            cfg_q <= cfg_word;
        end
    end

    // Memory answers in the same cycle, so data lands on this edge.
    always_ff @(posedge clk) begin
        if (reset || clear) begin
            load_data <= '0;
        end else if (load_phase) begin
            load_data <= rd_data;
        end
    end

    assign offset = `ADDR_W'(iter_index);   // Addresses wrap at the port width.

    assign mem_rd.req  = load_phase;
    assign mem_rd.addr = cfg_q.rd_base + offset;

    assign mem_wr.req  = store_phase && cfg_q.wr_en;
    assign mem_wr.addr = cfg_q.wr_base + offset;
    assign mem_wr.data = store_data;

endmodule

//--- source/pe_cell.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module pe_cell (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 clear,
    input  logic                 cfg_load,
    input  cgra_pkg::pe_config_t cfg_word,
    input  logic                 step,
    input  logic [`DATA_W-1:0]   north_in,
    input  logic [`DATA_W-1:0]   south_in,
    input  logic [`DATA_W-1:0]   west_in,
    output logic [`DATA_W-1:0]   data_out
);
    import cgra_pkg::*;

    localparam int SH_W = $clog2(`DATA_W);

    pe_config_t         cfg_q;
    logic [`DATA_W-1:0] op_a;
    logic [`DATA_W-1:0] op_b;
    logic [`DATA_W-1:0] alu_out;

    function automatic logic [`DATA_W-1:0] pick(input src_sel_t sel);
        case (sel)
            SRC_NORTH: pick = north_in;
            SRC_SOUTH: pick = south_in;
            SRC_WEST:  pick = west_in;
            SRC_SELF:  pick = data_out;
            SRC_IMM:   pick = `DATA_W'(cfg_q.imm);
            default:   pick = '0;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_q <= '0;
        end else if (cfg_load) begin
            cfg_q <= cfg_word;
        end
    end

    always_comb begin
        op_a = pick(cfg_q.src_a);
        op_b = pick(cfg_q.src_b);
        case (cfg_q.op)
            PASS_A:  alu_out = op_a;
            ADD:     alu_out = op_a + op_b;
            SUB:     alu_out = op_a - op_b;
            MUL:     alu_out = op_a * op_b;
            AND:     alu_out = op_a & op_b;
            OR:      alu_out = op_a | op_b;
            XOR:     alu_out = op_a ^ op_b;
            SHL:     alu_out = op_a << op_b[SH_W-1:0];
            default: alu_out = op_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            data_out <= '0;
        end else if (step) begin
            data_out <= alu_out;   // One update per compute cycle.
        end
    end

endmodule

//--- source/run_sequencer.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module run_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic [`ITER_W-1:0] iterations,
    input  logic               cfg_valid,
    input  logic               frame_end,
    output logic               cfg_en,
    output logic               clear,
    output logic               frame_run,
    output logic               busy,
    output logic               done
);
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISH
    } seq_state_t;

    seq_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        // An empty run goes straight to done.
                        state <= (iterations == '0) ? FINISH : RUN;
                    end
                end
                RUN: begin
                    if (frame_end) begin
                        state <= FINISH;
                    end
                end
                FINISH:  state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Array state is wiped on the same edge that accepts start.
    assign clear = start && (state == IDLE);

    assign cfg_en    = cfg_valid && (state == IDLE);   // No rewrites mid run.
    assign frame_run = (state == RUN);
    assign busy      = (state == RUN);
    assign done      = (state == FINISH);

endmodule

//--- source/frame_timer.sv
`timescale 1ns/1ps
`include "cgra_settings.svh"

module frame_timer (
    input  logic               clk,
    input  logic               reset,
    input  logic               frame_run,
    input  logic [`ITER_W-1:0] iterations,
    output logic               load_phase,
    output logic               compute_phase,
    output logic               store_phase,
    output logic               frame_end,
    output logic [`ITER_W-1:0] iter_index
);
    localparam int PH_W = $clog2(`FRAME_CYCLES);
    localparam logic [PH_W-1:0] LAST_PH = PH_W'(`FRAME_CYCLES - 1);

    logic [PH_W-1:0]    phase;
    logic [`ITER_W-1:0] iter_total;

    always_ff @(posedge clk) begin
        if (reset || !frame_run) begin
            phase      <= '0;
            iter_index <= '0;
        end else begin
            phase <= (phase == LAST_PH) ? '0 : phase + 1'b1;
            if (phase == LAST_PH) begin
                iter_index <= iter_index + 1'b1;   // Next frame.
            end
        end
    end

    // Count is held from the start edge for the whole run.
    always_ff @(posedge clk) begin
        if (!frame_run) begin
            iter_total <= iterations;
        end
    end

    assign load_phase    = frame_run && (phase == '0);
    assign compute_phase = frame_run && (phase != '0) && (phase != LAST_PH);
    assign store_phase   = frame_run && (phase == LAST_PH);
    assign frame_end     = store_phase && (iter_index == iter_total - 1'b1);

endmodule

//--- source/cgra_pkg.sv
`include "cgra_settings.svh"

package cgra_pkg;

    typedef enum logic [2:0] {
        PASS_A = 3'd0,
        ADD    = 3'd1,
        SUB    = 3'd2,
        MUL    = 3'd3,   // Low half of the product.
        AND    = 3'd4,
        OR     = 3'd5,
        XOR    = 3'd6,
        SHL    = 3'd7
    } pe_op_t;

    typedef enum logic [2:0] {
        SRC_NORTH = 3'd0,
        SRC_SOUTH = 3'd1,
        SRC_WEST  = 3'd2,
        SRC_SELF  = 3'd3,
        SRC_IMM   = 3'd4,
        SRC_ZERO  = 3'd5
    } src_sel_t;

    typedef struct packed {
        pe_op_t      op;
        src_sel_t    src_a;
        src_sel_t    src_b;
        logic [15:0] imm;    // Zero extended.
    } pe_config_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] rd_base;
        logic [`ADDR_W-1:0] wr_base;
        logic               wr_en;
    } lsu_config_t;

    localparam int CFG_WORD_W = $bits(pe_config_t);
    localparam logic [1:0] LSU_SLOT = 2'd3;   // Slots 0 to 2 are the PEs.

    typedef struct packed {
        logic                           valid;
        logic [$clog2(`CGRA_ROWS)-1:0]  row;
        logic [1:0]                     slot;
        logic [CFG_WORD_W-1:0]          word;
    } cfg_write_t;

    typedef struct packed {
        logic               req;
        logic [`ADDR_W-1:0] addr;
    } mem_rd_t;

    typedef struct packed {
        logic               req;
        logic [`ADDR_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } mem_wr_t;

endpackage

//--- include/cgra_settings.svh
`ifndef CGRA_SETTINGS_SVH
`define CGRA_SETTINGS_SVH

// Grid shape, four rows of three PEs.
`define CGRA_ROWS    4
`define CGRA_COLS    3

`define DATA_W       32
`define ADDR_W       8     // Word address into one row memory.
`define ITER_W       8
`define FRAME_CYCLES 8     // Load, six compute steps, store.

`endif
